// File: Bender.yml
package:
  name: periph_top

sources:
  - design/periph_pkg.sv
  - design/bus_decode.sv
  - design/read_return.sv
  - design/gpio_regs.sv
  - design/pin_out_mux.sv
  - design/edge_counter.sv
  - design/periph_top.sv
  - target: test
    files:
      - bench/tb_periph_top.sv

// File: bench/tb_periph_top.sv
// Table entries share state (pins, count, hold flag), so their order matters; inputs move on negedge
`timescale 1ns/1ps

module tb_periph_top;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int READY_LIMIT  = 16;    // Cycles a read may wait for ready
    localparam int STEP_BUDGET  = 200;   // Watchdog cycles per table entry

    localparam logic [2:0] OP_WRITE     = 3'd0;
    localparam logic [2:0] OP_READ      = 3'd1;
    localparam logic [2:0] OP_READ_HOLD = 3'd2;   // Read without the complete pulse
    localparam logic [2:0] OP_PULSE     = 3'd3;
    localparam logic [2:0] OP_SET_IN    = 3'd4;
    localparam logic [2:0] OP_COMPLETE  = 3'd5;

    // Slot base addresses built from the address map
    localparam periph_pkg::addr_t GPIO_BASE = {1'b0, periph_pkg::SLOT_GPIO, 6'h00};
    localparam periph_pkg::addr_t EDGE_BASE =
        {periph_pkg::ADDR_SIMPLE_TAG, 1'b0, periph_pkg::SLOT_EDGE, 4'h0};
    localparam periph_pkg::addr_t USER5_ADDR = {1'b0, 4'd5, 6'h00};
    localparam periph_pkg::addr_t TOP_ADDR   = 11'h610;   // Bits 10:9 = 11, low bits as the counter

    typedef struct packed {
        logic [2:0]        op;
        periph_pkg::addr_t addr;
        periph_pkg::byte_t data;
        periph_pkg::word_t exp_rd;
        periph_pkg::byte_t exp_uo;
    } step_t;

    logic                clk;
    logic                rst_n;
    periph_pkg::byte_t   i_ui_in;
    periph_pkg::byte_t   o_uo_out;
    periph_pkg::addr_t   i_addr;
    periph_pkg::word_t   i_data_in;
    periph_pkg::size_n_t i_write_n;
    periph_pkg::size_n_t i_read_n;
    periph_pkg::word_t   o_data_out;
    logic                o_data_ready;
    logic                i_read_complete;

    step_t steps[$];
    int    errors      = 0;
    int    failed      = 0;
    bit    table_ready = 1'b0;

    periph_top periph_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (i_ui_in),
        .o_uo_out        (o_uo_out),
        .i_addr          (i_addr),
        .i_data_in       (i_data_in),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready),
        .i_read_complete (i_read_complete)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic void add_step(input logic [2:0] op, input periph_pkg::addr_t addr,
                                     input periph_pkg::byte_t data,
                                     input periph_pkg::word_t exp_rd,
                                     input periph_pkg::byte_t exp_uo);
        step_t s;
        s = '{op, addr, data, exp_rd, exp_uo};
        steps.push_back(s);
    endfunction

    function automatic periph_pkg::addr_t fsel_addr(input int pin);
        return GPIO_BASE + periph_pkg::GPIO_OFS_FSEL_BASE + 11'(4 * pin);
    endfunction

    function automatic string op_name(input logic [2:0] op);
        case (op)
            OP_WRITE:     return "write";
            OP_READ:      return "read";
            OP_READ_HOLD: return "read-hold";
            OP_PULSE:     return "pulse";
            OP_SET_IN:    return "set-input";
            default:      return "complete";
        endcase
    endfunction

    // All calls start and end on a falling edge
    task automatic write_reg(input periph_pkg::addr_t addr, input periph_pkg::byte_t data);
        i_addr    = addr;
        i_data_in = {24'h0, data};
        i_write_n = 2'b00;   // Byte write
        #(CLK_PERIOD / 4);
        assert (o_data_ready) else begin
            $display("CHECK FAILED: o_data_ready got %h expected %h", o_data_ready, 1'b1);
            errors++;
        end
        @(negedge clk);
        i_write_n = periph_pkg::SIZE_NONE;
    endtask

    task automatic read_reg(input periph_pkg::addr_t addr, input bit complete,
                            output periph_pkg::word_t data);
        int waited;
        waited   = 0;
        i_addr   = addr;
        i_read_n = 2'b10;   // Word read
        do begin
            @(negedge clk);
            waited++;
        end while (!o_data_ready && waited < READY_LIMIT);
        if (!o_data_ready) begin
            $display("Read at address %h got no ready within %0d cycles", addr, READY_LIMIT);
            errors++;
        end else begin
            assert (waited == 1) else begin
                $display("CHECK FAILED: o_data_ready latency got %h expected %h", waited, 1);
                errors++;
            end
        end
        data            = o_data_out;
        i_read_n        = periph_pkg::SIZE_NONE;
        i_read_complete = complete;
        @(negedge clk);
        i_read_complete = 1'b0;
        assert (!o_data_ready) else begin
            $display("CHECK FAILED: o_data_ready got %h expected %h", o_data_ready, 1'b0);
            errors++;
        end
    endtask

    // Rising edges end up four cycles apart
    task automatic pulse_input(input periph_pkg::byte_t mask);
        i_ui_in = i_ui_in | mask;
        repeat (2) @(negedge clk);
        i_ui_in = i_ui_in & ~mask;
        repeat (2) @(negedge clk);
    endtask

    task automatic drive_input(input periph_pkg::byte_t value);
        i_ui_in = value;
        @(negedge clk);
    endtask

    task automatic release_read();
        i_read_complete = 1'b1;
        @(negedge clk);
        i_read_complete = 1'b0;
    endtask

    task automatic apply_step(input int idx, input step_t s);
        periph_pkg::word_t got;
        int                errors_before;
        errors_before = errors;
        case (s.op)
            OP_WRITE:  write_reg(s.addr, s.data);
            OP_PULSE:  pulse_input(s.data);
            OP_SET_IN: drive_input(s.data);
            OP_READ, OP_READ_HOLD: begin
                read_reg(s.addr, s.op == OP_READ, got);
                assert (got == s.exp_rd) else begin
                    $display("CHECK FAILED: o_data_out got %h expected %h", got, s.exp_rd);
                    errors++;
                end
            end
            default: begin
                // Held data must survive until the pulse arrives
                assert (o_data_out == s.exp_rd) else begin
                    $display("CHECK FAILED: o_data_out got %h expected %h", o_data_out, s.exp_rd);
                    errors++;
                end
                release_read();
            end
        endcase
        assert (o_uo_out == s.exp_uo) else begin
            $display("CHECK FAILED: o_uo_out got %h expected %h", o_uo_out, s.exp_uo);
            errors++;
        end
        if (errors != errors_before) failed++;
        $display("test %0d %s addr %h: %s", idx, op_name(s.op), s.addr,
                 (errors == errors_before) ? "ok" : "FAILED");
    endtask

    task automatic build_table();
        periph_pkg::word_t fsel_rst;
        fsel_rst = periph_pkg::word_t'(periph_pkg::FSEL_RESET);
        // Reset state
        add_step(OP_READ, GPIO_BASE + periph_pkg::GPIO_OFS_OUT, 8'h00, 32'h0, 8'h00);
        for (int i = 0; i < periph_pkg::NUM_PINS; i++) begin
            add_step(OP_READ, fsel_addr(i), 8'h00, fsel_rst, 8'h00);
        end
        // GPIO output and input
        add_step(OP_WRITE, GPIO_BASE + periph_pkg::GPIO_OFS_OUT, 8'hA5, 32'h0, 8'hA5);
        add_step(OP_READ, GPIO_BASE + periph_pkg::GPIO_OFS_OUT, 8'h00, 32'hA5, 8'hA5);
        add_step(OP_SET_IN, 11'h0, 8'h3C, 32'h0, 8'hA5);
        add_step(OP_READ, GPIO_BASE + periph_pkg::GPIO_OFS_IN, 8'h00, 32'h3C, 8'hA5);
        add_step(OP_SET_IN, 11'h0, 8'h00, 32'h0, 8'hA5);
        add_step(OP_WRITE, GPIO_BASE + periph_pkg::GPIO_OFS_OUT, 8'h00, 32'h0, 8'h00);
        // Edge counter on bit 2
        add_step(OP_WRITE, EDGE_BASE + periph_pkg::EDGE_OFS_SRC, 8'h02, 32'h0, 8'h00);
        add_step(OP_READ, EDGE_BASE + periph_pkg::EDGE_OFS_SRC, 8'h00, 32'h2, 8'h00);
        for (int i = 0; i < 5; i++) add_step(OP_PULSE, 11'h0, 8'h04, 32'h0, 8'h00);
        add_step(OP_READ, EDGE_BASE + periph_pkg::EDGE_OFS_COUNT, 8'h00, 32'h5, 8'h00);
        add_step(OP_WRITE, EDGE_BASE + periph_pkg::EDGE_OFS_COUNT, 8'h55, 32'h0, 8'h00);
        add_step(OP_READ, EDGE_BASE + periph_pkg::EDGE_OFS_COUNT, 8'h00, 32'h0, 8'h00);
        for (int i = 0; i < 8; i++) add_step(OP_PULSE, 11'h0, 8'h04, 32'h0, 8'h00);
        add_step(OP_READ, EDGE_BASE + periph_pkg::EDGE_OFS_COUNT, 8'h00, 32'h8, 8'h00);
        // Pin 3 redirected to the counter, count bit 3 is set
        add_step(OP_WRITE, fsel_addr(3), 8'h11, 32'h0, 8'h08);
        add_step(OP_READ, fsel_addr(3), 8'h00, 32'h11, 8'h08);
        add_step(OP_WRITE, fsel_addr(3), 8'(periph_pkg::FSEL_RESET), 32'h0, 8'h00);
        // Unmapped slots
        add_step(OP_READ, USER5_ADDR, 8'h00, 32'h0, 8'h00);
        add_step(OP_READ, TOP_ADDR, 8'h00, 32'h0, 8'h00);
        add_step(OP_WRITE, TOP_ADDR, 8'hFF, 32'h0, 8'h00);
        add_step(OP_WRITE, USER5_ADDR, 8'hFF, 32'h0, 8'h00);
        add_step(OP_READ, GPIO_BASE + periph_pkg::GPIO_OFS_OUT, 8'h00, 32'h0, 8'h00);
        add_step(OP_READ, EDGE_BASE + periph_pkg::EDGE_OFS_COUNT, 8'h00, 32'h8, 8'h00);
        // Held read data
        add_step(OP_READ_HOLD, EDGE_BASE + periph_pkg::EDGE_OFS_COUNT, 8'h00, 32'h8, 8'h00);
        add_step(OP_PULSE, 11'h0, 8'h04, 32'h0, 8'h00);
        add_step(OP_READ_HOLD, EDGE_BASE + periph_pkg::EDGE_OFS_COUNT, 8'h00, 32'h8, 8'h00);
        add_step(OP_COMPLETE, 11'h0, 8'h00, 32'h8, 8'h00);
        add_step(OP_READ, EDGE_BASE + periph_pkg::EDGE_OFS_COUNT, 8'h00, 32'h9, 8'h00);
    endtask

    initial begin
        rst_n           = 1'b0;
        i_ui_in         = '0;
        i_addr          = '0;
        i_data_in       = '0;
        i_write_n       = periph_pkg::SIZE_NONE;
        i_read_n        = periph_pkg::SIZE_NONE;
        i_read_complete = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (o_uo_out == 8'h00 && !o_data_ready) else begin
            $display("CHECK FAILED: o_uo_out got %h expected %h, o_data_ready got %h expected %h",
                     o_uo_out, 8'h00, o_data_ready, 1'b0);
            errors++;
            failed++;
        end
        $display("test reset: %s", (errors == 0) ? "ok" : "FAILED");

        foreach (steps[i]) apply_step(i, steps[i]);

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 steps.size() + 1, failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Run limit scales with the table length
    initial begin
        wait (table_ready);
        repeat (RESET_CYCLES + STEP_BUDGET * steps.size()) @(posedge clk);
        $display("Watchdog expired: the bus hung before the table finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: design/bus_decode.sv
// Only two slots decode; every other address, including bits 10:9 = 11, reads zero
`timescale 1ns/1ps

module bus_decode (
    input  periph_pkg::addr_t i_addr,
    input  periph_pkg::word_t i_gpio_rdata,
    input  periph_pkg::byte_t i_edge_rdata,
    output logic              o_sel_gpio,
    output logic              o_sel_edge,
    output periph_pkg::word_t o_peri_rdata
);

    periph_pkg::slot_t simple_slot;
    periph_pkg::slot_t user_slot;
    logic              in_simple;
    logic              in_user;

    assign simple_slot = i_addr[7:4];   // 16 byte windows
    assign user_slot   = i_addr[9:6];   // 64 byte windows
    assign in_simple   = (i_addr[10:9] == periph_pkg::ADDR_SIMPLE_TAG);
    assign in_user     = !i_addr[10];

    always_comb begin
        o_sel_gpio   = 1'b0;
        o_sel_edge   = 1'b0;
        o_peri_rdata = '0;   // Unmapped slots read zero

        if (in_simple) begin
            if (simple_slot == periph_pkg::SLOT_EDGE) begin
                o_sel_edge   = 1'b1;
                o_peri_rdata = periph_pkg::word_t'(i_edge_rdata);
            end
        end else if (in_user) begin
            if (user_slot == periph_pkg::SLOT_GPIO) begin
                o_sel_gpio   = 1'b1;
                o_peri_rdata = i_gpio_rdata;
            end
        end
    end

endmodule

// File: design/edge_counter.sv
// Count wraps at 8 bits; changing the source can count one spurious edge from the old bit
`timescale 1ns/1ps

module edge_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_sel,
    input  logic [3:0]          i_addr_ofs,
    input  periph_pkg::size_n_t i_write_n,
    input  periph_pkg::byte_t   i_data_in,
    input  periph_pkg::byte_t   i_ui_in,
    output periph_pkg::byte_t   o_rdata,
    output periph_pkg::byte_t   o_uo_out
);

    logic [2:0]        src_r;
    logic              src_dly_r;
    periph_pkg::byte_t count_r;
    logic              wr_en;
    logic              clr_count;
    logic              src_bit;
    logic              rise;

    assign wr_en     = i_sel && (i_write_n != periph_pkg::SIZE_NONE);
    assign clr_count = wr_en && (i_addr_ofs == periph_pkg::EDGE_OFS_COUNT);   // Data ignored
    assign src_bit   = i_ui_in[src_r];
    assign rise      = src_bit && !src_dly_r;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src_r     <= '0;
            src_dly_r <= 1'b0;
            count_r   <= '0;
        end else begin
            src_dly_r <= src_bit;
            if (wr_en && i_addr_ofs == periph_pkg::EDGE_OFS_SRC) src_r <= i_data_in[2:0];

            if (clr_count) begin
                count_r <= '0;
            end else if (rise) begin
                count_r <= count_r + 8'd1;
            end
        end
    end

    always_comb begin
        case (i_addr_ofs)
            periph_pkg::EDGE_OFS_COUNT: o_rdata = count_r;
            periph_pkg::EDGE_OFS_SRC:   o_rdata = periph_pkg::byte_t'(src_r);
            default:                    o_rdata = '0;
        endcase
    end

    assign o_uo_out = count_r;   // Lanes show the live count

    // No input can advance the count by more than one step
    a_count_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        !clr_count |=> (count_r == $past(count_r)) ||
                       (count_r == periph_pkg::byte_t'($past(count_r) + 8'd1))
    ) else $error("edge count jumped by more than one");

endmodule

// File: design/gpio_regs.sv
// Only the low data byte is written whatever the access size; select bit 4 picks simple slots
`timescale 1ns/1ps

module gpio_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_sel,
    input  logic [5:0]            i_addr_ofs,
    input  periph_pkg::size_n_t   i_write_n,
    input  periph_pkg::byte_t     i_data_in,
    input  periph_pkg::byte_t     i_ui_in,
    output periph_pkg::word_t     o_rdata,
    output periph_pkg::byte_t     o_gpio_out,
    output periph_pkg::func_sel_t o_func_sel [periph_pkg::NUM_PINS]
);

    logic       wr_en;
    logic       is_fsel;
    logic [2:0] fsel_pin;

    assign wr_en = i_sel && (i_write_n != periph_pkg::SIZE_NONE);

    // Select words sit on a 4 byte stride in the upper half of the window
    assign is_fsel  = ((i_addr_ofs & ~6'h1c) == periph_pkg::GPIO_OFS_FSEL_BASE);
    assign fsel_pin = i_addr_ofs[4:2];

    // Output byte
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
        end else if (wr_en && i_addr_ofs == periph_pkg::GPIO_OFS_OUT) begin
            o_gpio_out <= i_data_in;
        end
    end

    // One function select per pin
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < periph_pkg::NUM_PINS; i++) begin
                o_func_sel[i] <= periph_pkg::FSEL_RESET;
            end
        end else if (wr_en && is_fsel) begin
            for (int i = 0; i < periph_pkg::NUM_PINS; i++) begin
                if (fsel_pin == i) o_func_sel[i] <= i_data_in[4:0];
            end
        end
    end

    // Readback
    always_comb begin
        if (i_addr_ofs == periph_pkg::GPIO_OFS_OUT) begin
            o_rdata = periph_pkg::word_t'(o_gpio_out);
        end else if (i_addr_ofs == periph_pkg::GPIO_OFS_IN) begin
            o_rdata = periph_pkg::word_t'(i_ui_in);   // Pins as seen now
        end else if (is_fsel) begin
            o_rdata = periph_pkg::word_t'(o_func_sel[fsel_pin]);
        end else begin
            o_rdata = '0;
        end
    end

    // Pins come out of reset on the GPIO byte
    for (genvar g = 0; g < periph_pkg::NUM_PINS; g++) begin : g_fsel_check
        a_fsel_reset: assert property (
            @(posedge clk) !rst_n |=> o_func_sel[g] == periph_pkg::FSEL_RESET
        ) else $error("pin %0d select not at reset value after reset", g);
    end

endmodule

// File: design/periph_pkg.sv
// Shared bus map; only GPIO (user slot 1) and the edge counter (simple slot 1) exist
package periph_pkg;

    // Bus field types
    typedef logic [10:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  size_n_t;     // 11 none, 00 byte, 01 half, 10 word
    typedef logic [3:0]  slot_t;
    typedef logic [4:0]  func_sel_t;   // Bit 4 picks the simple region

    localparam size_n_t SIZE_NONE = 2'b11;

    // Slot numbers within each region
    localparam slot_t SLOT_GPIO = 4'd1;   // User region
    localparam slot_t SLOT_EDGE = 4'd1;   // Simple region

    // GPIO register offsets, 64 byte window
    localparam logic [5:0] GPIO_OFS_OUT       = 6'h00;
    localparam logic [5:0] GPIO_OFS_IN        = 6'h04;
    localparam logic [5:0] GPIO_OFS_FSEL_BASE = 6'h20;  // Pin i at base + 4*i

    // Edge counter offsets, 16 byte window
    localparam logic [3:0] EDGE_OFS_COUNT = 4'h0;
    localparam logic [3:0] EDGE_OFS_SRC   = 4'h1;

    localparam int NUM_PINS = 8;

    // Every pin starts driven by the GPIO output byte
    localparam func_sel_t FSEL_RESET = {1'b0, SLOT_GPIO};

    // Address bits 10:9 of the byte-interface region
    localparam logic [1:0] ADDR_SIMPLE_TAG = 2'b10;

endpackage

// File: design/periph_top.sv
// No interrupts and no stalls; the core must not request a read and a write together
`timescale 1ns/1ps

module periph_top (
    input  logic                clk,
    input  logic                rst_n,
    input  periph_pkg::byte_t   i_ui_in,
    output periph_pkg::byte_t   o_uo_out,
    input  periph_pkg::addr_t   i_addr,
    input  periph_pkg::word_t   i_data_in,
    input  periph_pkg::size_n_t i_write_n,
    input  periph_pkg::size_n_t i_read_n,
    output periph_pkg::word_t   o_data_out,
    output logic                o_data_ready,
    input  logic                i_read_complete
);

    logic                  sel_gpio;
    logic                  sel_edge;
    periph_pkg::word_t     peri_rdata;
    periph_pkg::word_t     gpio_rdata;
    periph_pkg::byte_t     edge_rdata;
    periph_pkg::byte_t     gpio_out;
    periph_pkg::byte_t     edge_lanes;
    periph_pkg::func_sel_t func_sel [periph_pkg::NUM_PINS];

    bus_decode bus_decode_i (
        .i_addr       (i_addr),
        .i_gpio_rdata (gpio_rdata),
        .i_edge_rdata (edge_rdata),
        .o_sel_gpio   (sel_gpio),
        .o_sel_edge   (sel_edge),
        .o_peri_rdata (peri_rdata)
    );

    read_return read_return_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .i_peri_rdata    (peri_rdata),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

    // User slot, 64 byte window
    gpio_regs gpio_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel      (sel_gpio),
        .i_addr_ofs (i_addr[5:0]),
        .i_write_n  (i_write_n),
        .i_data_in  (i_data_in[7:0]),
        .i_ui_in    (i_ui_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel)
    );

    // Simple slot, 16 byte window
    edge_counter edge_counter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel      (sel_edge),
        .i_addr_ofs (i_addr[3:0]),
        .i_write_n  (i_write_n),
        .i_data_in  (i_data_in[7:0]),
        .i_ui_in    (i_ui_in),
        .o_rdata    (edge_rdata),
        .o_uo_out   (edge_lanes)
    );

    pin_out_mux pin_out_mux_i (
        .i_func_sel   (func_sel),
        .i_gpio_lanes (gpio_out),
        .i_edge_lanes (edge_lanes),
        .o_uo_out     (o_uo_out)
    );

endmodule

// File: design/pin_out_mux.sv
// Purely combinational; selects naming a slot with no lanes drive the pin low
`timescale 1ns/1ps

module pin_out_mux (
    input  periph_pkg::func_sel_t i_func_sel [periph_pkg::NUM_PINS],
    input  periph_pkg::byte_t     i_gpio_lanes,
    input  periph_pkg::byte_t     i_edge_lanes,
    output periph_pkg::byte_t     o_uo_out
);

    always_comb begin
        logic              is_simple;
        periph_pkg::slot_t slot;

        o_uo_out = '0;
        for (int i = 0; i < periph_pkg::NUM_PINS; i++) begin
            is_simple = i_func_sel[i][4];
            slot      = i_func_sel[i][3:0];

            // Each pin takes its own bit of the chosen slot's lanes
            if (is_simple) begin
                if (slot == periph_pkg::SLOT_EDGE) o_uo_out[i] = i_edge_lanes[i];
            end else begin
                if (slot == periph_pkg::SLOT_GPIO) o_uo_out[i] = i_gpio_lanes[i];
            end
        end
    end

endmodule

// File: design/read_return.sv
// Every slot answers at once, so read ready is one registered cycle with no stall input
`timescale 1ns/1ps

module read_return (
    input  logic                clk,
    input  logic                rst_n,
    input  periph_pkg::size_n_t i_read_n,
    input  periph_pkg::size_n_t i_write_n,
    input  logic                i_read_complete,
    input  periph_pkg::word_t   i_peri_rdata,
    output periph_pkg::word_t   o_data_out,
    output logic                o_data_ready
);

    logic              read_req;
    logic              write_req;
    logic              hold_r;
    logic              ready_r;
    periph_pkg::word_t data_out_r;

    assign read_req  = (i_read_n != periph_pkg::SIZE_NONE);
    assign write_req = (i_write_n != periph_pkg::SIZE_NONE);

    // Hold flag and registered ready
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_r  <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) hold_r <= 1'b0;
            if (!hold_r && read_req) hold_r <= 1'b1;   // Capture wins over clear
            ready_r <= read_req;   // Drops one cycle after the request
        end
    end

    // First read of a transfer is captured and then frozen
    always_ff @(posedge clk) begin
        if (!hold_r && read_req) begin
            data_out_r <= i_peri_rdata;
        end
    end

    assign o_data_out   = data_out_r;
    assign o_data_ready = ready_r || write_req;   // Writes complete immediately

    // The core issues one kind of access at a time
    a_no_read_write_overlap: assert property (
        @(posedge clk) disable iff (!rst_n) !(read_req && write_req)
    ) else $error("read and write requested in the same cycle");

endmodule

// File: tb.f
design/periph_pkg.sv
design/bus_decode.sv
design/read_return.sv
design/gpio_regs.sv
design/pin_out_mux.sv
design/edge_counter.sv
design/periph_top.sv
bench/tb_periph_top.sv
